// File: source/swap_types_pkg.sv
`default_nettype none

package swap_types_pkg;

    localparam int ADDR_NIBBLES  = 2;
    localparam int DATA_NIBBLES  = 4;
    localparam int SHIFT_NIBBLES = ADDR_NIBBLES + DATA_NIBBLES;
    localparam int ADDR_W        = 4 * ADDR_NIBBLES;
    localparam int DATA_W        = 4 * DATA_NIBBLES;
    localparam int RX_DEPTH      = 4;
    localparam int TX_CREDITS    = 4;
    localparam int RX_PTR_W      = $clog2(RX_DEPTH);
    localparam int RX_CNT_W      = $clog2(RX_DEPTH + 1);
    localparam int TX_CNT_W      = $clog2(TX_CREDITS + 1);

    typedef logic [3:0] nibble_t;

    // Address sits at the top so new nibbles enter at the address end.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } swap_fields_t;

    typedef union packed {
        swap_fields_t                fields;
        nibble_t [SHIFT_NIBBLES-1:0] nibs;
    } shift_reg_u;

    typedef struct packed {
        logic    valid;
        nibble_t nibble;
    } nibble_beat_t;

endpackage

`default_nettype wire

// File: source/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    localparam int MEM_WAIT  = 2;
    localparam int WAIT_W    = $clog2(MEM_WAIT + 1);
    localparam int MEM_WORDS = 1 << swap_types_pkg::ADDR_W;

    typedef struct packed {
        logic                              read;
        logic                              write;
        logic [swap_types_pkg::ADDR_W-1:0] addr;
        logic [swap_types_pkg::DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                              read_ack;
        logic                              write_ack;
        logic [swap_types_pkg::DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: source/nibble_link.sv
`timescale 1ns/1ns
`default_nettype none

module nibble_link (
    input  wire                               clk,
    input  wire                               nRst,
    input  wire swap_types_pkg::nibble_beat_t i_rx,
    output logic                              o_rx_credit,
    output swap_types_pkg::nibble_beat_t      o_tx,
    input  wire                               i_tx_credit,
    input  wire                               i_shift_ready,
    input  wire swap_types_pkg::nibble_t      i_out_nibble,
    output logic                              o_shift,
    output swap_types_pkg::nibble_t           o_in_nibble
);

    import swap_types_pkg::*;

    nibble_t             fifo_q [RX_DEPTH];
    logic [RX_PTR_W-1:0] wr_ptr_q;
    logic [RX_PTR_W-1:0] rd_ptr_q;
    logic [RX_CNT_W-1:0] rx_cnt_q;
    logic [TX_CNT_W-1:0] tx_cnt_q;
    logic                rx_ready;
    logic                tx_ready;

    assign rx_ready = (rx_cnt_q != '0);
    assign tx_ready = (tx_cnt_q != '0);

    // Shift only when a nibble waits and the displaced one can be sent.
    assign o_shift     = rx_ready && tx_ready && i_shift_ready;
    assign o_rx_credit = o_shift;
    assign o_in_nibble = fifo_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (i_rx.valid) begin
            fifo_q[wr_ptr_q] <= i_rx.nibble;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            rx_cnt_q <= '0;
        end else begin
            if (i_rx.valid) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (o_shift) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({i_rx.valid, o_shift})
                2'b10:   rx_cnt_q <= rx_cnt_q + 1'b1;
                2'b01:   rx_cnt_q <= rx_cnt_q - 1'b1;
                default: rx_cnt_q <= rx_cnt_q;
            endcase
        end
    end

    // Transmit credits, spent per shift and returned by the host.
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            tx_cnt_q <= TX_CNT_W'(TX_CREDITS);
        end else begin
            case ({i_tx_credit, o_shift})
                2'b10:   tx_cnt_q <= tx_cnt_q + 1'b1;
                2'b01:   tx_cnt_q <= tx_cnt_q - 1'b1;
                default: tx_cnt_q <= tx_cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            o_tx <= '0;
        end else begin
            o_tx.valid  <= o_shift;
            o_tx.nibble <= i_out_nibble;
        end
    end

endmodule

`default_nettype wire

// File: source/nibble_shift_swap.sv
`timescale 1ns/1ns
`default_nettype none

module nibble_shift_swap (
    input  wire                             clk,
    input  wire                             nRst,
    input  wire                             i_shift,
    input  wire swap_types_pkg::nibble_t    i_in_nibble,
    output swap_types_pkg::nibble_t         o_out_nibble,
    output logic                            o_shift_ready,
    input  wire                             i_swap_req,
    output logic                            o_swap_ack,
    output mem_bus_pkg::mem_req_t           o_mem_req,
    input  wire mem_bus_pkg::mem_rsp_t      i_mem_rsp
);

    import swap_types_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ_1,
        WRITE,
        READ_2
    } swap_state_t;

    swap_state_t       state_q;
    shift_reg_u        shift_q;
    logic [DATA_W-1:0] rd_word_q;
    logic              read_q;
    logic              write_q;
    logic [DATA_W-1:0] data_xor;

    assign data_xor      = shift_q.fields.data ^ i_mem_rsp.rdata;
    assign o_out_nibble  = shift_q.nibs[0];
    assign o_shift_ready = (state_q == IDLE);

    // Write data is (D ^ M) ^ M, so memory receives the old register data.
    assign o_mem_req.read  = read_q;
    assign o_mem_req.write = write_q;
    assign o_mem_req.addr  = shift_q.fields.addr;
    assign o_mem_req.wdata = shift_q.fields.data ^ rd_word_q;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state_q    <= IDLE;
            shift_q    <= '0;
            read_q     <= 1'b0;
            write_q    <= 1'b0;
            o_swap_ack <= 1'b0;
        end else begin
            o_swap_ack <= 1'b0;
            case (state_q)
                IDLE: begin
                    // A shift in the same cycle takes priority over the swap.
                    if (i_shift) begin
                        shift_q.nibs <= {i_in_nibble, shift_q.nibs[SHIFT_NIBBLES-1:1]};
                    end else if (i_swap_req && !o_swap_ack) begin
                        read_q  <= 1'b1;
                        state_q <= READ_1;
                    end
                end
                READ_1: begin
                    if (i_mem_rsp.read_ack) begin
                        shift_q.fields.data <= data_xor;
                        read_q              <= 1'b0;
                        write_q             <= 1'b1;
                        state_q             <= WRITE;
                    end
                end
                WRITE: begin
                    if (i_mem_rsp.write_ack) begin
                        write_q <= 1'b0;
                        read_q  <= 1'b1;
                        state_q <= READ_2;
                    end
                end
                READ_2: begin
                    // Second XOR leaves the old memory word in the data field.
                    if (i_mem_rsp.read_ack) begin
                        shift_q.fields.data <= data_xor;
                        read_q              <= 1'b0;
                        o_swap_ack          <= 1'b1;
                        state_q             <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Keep the first read word for the write-back.
    always_ff @(posedge clk) begin
        if ((state_q == READ_1) && i_mem_rsp.read_ack) begin
            rd_word_q <= i_mem_rsp.rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/swap_mem.sv
`timescale 1ns/1ns
`default_nettype none

module swap_mem (
    input  wire                        clk,
    input  wire                        nRst,
    input  wire mem_bus_pkg::mem_req_t i_req,
    output mem_bus_pkg::mem_rsp_t      o_rsp
);

    import swap_types_pkg::*;
    import mem_bus_pkg::*;

    logic [DATA_W-1:0] mem_q [MEM_WORDS];
    logic [WAIT_W-1:0] wait_q;
    logic              busy;
    logic              done;

    // The cycle of an acknowledgement does not count toward the next request.
    assign busy = (i_req.read || i_req.write) && !(o_rsp.read_ack || o_rsp.write_ack);
    assign done = busy && (wait_q == WAIT_W'(MEM_WAIT - 1));

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
            wait_q <= '0;
            o_rsp  <= '0;
        end else begin
            o_rsp.read_ack  <= done && i_req.read;
            o_rsp.write_ack <= done && i_req.write;

            if (done) begin
                wait_q <= '0;
            end else if (busy) begin
                wait_q <= wait_q + 1'b1;
            end

            // Read data lands together with its acknowledgement.
            if (done && i_req.read) begin
                o_rsp.rdata <= mem_q[i_req.addr];
            end
            if (done && i_req.write) begin
                mem_q[i_req.addr] <= i_req.wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/swap_top.sv
`timescale 1ns/1ns
`default_nettype none

module swap_top (
    input  wire                               clk,
    input  wire                               nRst,
    input  wire swap_types_pkg::nibble_beat_t i_rx,
    output logic                              o_rx_credit,
    output swap_types_pkg::nibble_beat_t      o_tx,
    input  wire                               i_tx_credit,
    input  wire                               i_swap_req,
    output logic                              o_swap_ack
);

    import swap_types_pkg::*;
    import mem_bus_pkg::*;

    logic     shift;
    logic     shift_ready;
    nibble_t  in_nibble;
    nibble_t  out_nibble;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    nibble_link nibble_link_i (
        .clk           (clk),
        .nRst          (nRst),
        .i_rx          (i_rx),
        .o_rx_credit   (o_rx_credit),
        .o_tx          (o_tx),
        .i_tx_credit   (i_tx_credit),
        .i_shift_ready (shift_ready),
        .i_out_nibble  (out_nibble),
        .o_shift       (shift),
        .o_in_nibble   (in_nibble)
    );

    nibble_shift_swap nibble_shift_swap_i (
        .clk           (clk),
        .nRst          (nRst),
        .i_shift       (shift),
        .i_in_nibble   (in_nibble),
        .o_out_nibble  (out_nibble),
        .o_shift_ready (shift_ready),
        .i_swap_req    (i_swap_req),
        .o_swap_ack    (o_swap_ack),
        .o_mem_req     (mem_req),
        .i_mem_rsp     (mem_rsp)
    );

    swap_mem swap_mem_i (
        .clk   (clk),
        .nRst  (nRst),
        .i_req (mem_req),
        .o_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// File: verification/swap_assert.sv
`timescale 1ns/1ns
`default_nettype none

module swap_assert (
    input wire                        clk,
    input wire                        nRst,
    input wire mem_bus_pkg::mem_req_t i_mem_req,
    input wire mem_bus_pkg::mem_rsp_t i_mem_rsp,
    input wire                        i_swap_ack,
    input wire                        i_shift_ready
);

    int fail_count = 0;

    // One port, so one operation at a time.
    one_op: assert property (@(posedge clk) disable iff (!nRst)
        !(i_mem_req.read && i_mem_req.write))
        else begin
            fail_count++;
            $error("memory read and write requested together");
        end

    ack_pulse: assert property (@(posedge clk) disable iff (!nRst)
        i_swap_ack |=> !i_swap_ack)
        else begin
            fail_count++;
            $error("swap acknowledge longer than one cycle");
        end

    read_hold: assert property (@(posedge clk) disable iff (!nRst)
        (i_mem_req.read && !i_mem_rsp.read_ack) |=> i_mem_req.read)
        else begin
            fail_count++;
            $error("read request dropped before its acknowledge");
        end

    write_hold: assert property (@(posedge clk) disable iff (!nRst)
        (i_mem_req.write && !i_mem_rsp.write_ack) |=> i_mem_req.write)
        else begin
            fail_count++;
            $error("write request dropped before its acknowledge");
        end

    // No shifting while the register is in use by a memory access.
    busy_no_shift: assert property (@(posedge clk) disable iff (!nRst)
        (i_mem_req.read || i_mem_req.write) |-> !i_shift_ready)
        else begin
            fail_count++;
            $error("shift ready while a memory request is pending");
        end

endmodule

bind nibble_shift_swap swap_assert swap_assert_i (
    .clk           (clk),
    .nRst          (nRst),
    .i_mem_req     (o_mem_req),
    .i_mem_rsp     (i_mem_rsp),
    .i_swap_ack    (o_swap_ack),
    .i_shift_ready (o_shift_ready)
);

`default_nettype wire

// File: verification/swap_tb.sv
`timescale 1ns/1ns
`default_nettype none

module swap_tb;

    import swap_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int NUM_SWAPS      = 400;
    localparam int MAX_PEND_SENDS = 3;
    localparam int MAX_NIBBLES    = SHIFT_NIBBLES + 7 + MAX_PEND_SENDS;
    // Three memory transactions plus the nibble traffic around one swap.
    localparam int SWAP_CYCLES    = 3 * (MEM_WAIT + 3) + 16 * MAX_NIBBLES + 64;
    localparam int TIMEOUT_CYCLES = (NUM_SWAPS + 1) * SWAP_CYCLES;

    logic         clk;
    logic         nRst;
    nibble_beat_t rx;
    logic         rx_credit;
    nibble_beat_t tx;
    logic         tx_credit;
    logic         swap_req;
    logic         swap_ack;

    logic [31:0]       rng_state;
    shift_reg_u        model_reg;
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    nibble_t           sent_q [$];
    swap_fields_t      expect_fields;
    shift_reg_u        collected;
    int                host_rx_credits;
    int                tx_owed;
    int                nibbles_left;
    int                pend_sends;
    int                collect_cnt;
    int                sent_total;
    int                credits_back;
    int                swaps_done;
    int                cycle_cnt = 0;
    bit                swap_pending;
    bit                collecting;

    swap_top swap_top_i (
        .clk         (clk),
        .nRst        (nRst),
        .i_rx        (rx),
        .o_rx_credit (rx_credit),
        .o_tx        (tx),
        .i_tx_credit (tx_credit),
        .i_swap_req  (swap_req),
        .o_swap_ack  (swap_ack)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure("Timeout: the run did not finish within the cycle limit.");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic compare_nibble(input string test, input nibble_t exp, input nibble_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", test, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_fields(input string test, input swap_fields_t exp,
                                  input swap_fields_t act);
        if (act !== exp) begin
            $display("Error: %s expected addr %h data %h actual addr %h data %h",
                     test, exp.addr, exp.data, act.addr, act.data);
            stop_run();
        end
    endtask

    // Called at the falling edge, where DUT outputs are stable.
    task automatic observe_outputs();
        nibble_t           nib_in;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] old_word;
        if (rx_credit) begin
            credits_back++;
            host_rx_credits++;
            if (credits_back > sent_total || host_rx_credits > RX_DEPTH) begin
                report_failure("DUT returned more receive credits than nibbles were sent.");
            end
        end
        if (tx.valid) begin
            if (tx_owed >= TX_CREDITS) begin
                report_failure("DUT sent a nibble while it held no transmit credit.");
            end
            if (sent_q.size() == 0) begin
                report_failure("DUT sent a nibble although no nibble was waiting.");
            end
            tx_owed++;
            // The register read back after a swap is checked as a whole.
            if (collecting) begin
                collected.nibs[collect_cnt] = tx.nibble;
                collect_cnt++;
                if (collect_cnt == SHIFT_NIBBLES) begin
                    compare_fields("swap_exchange", expect_fields, collected.fields);
                    collecting = 1'b0;
                end
            end else begin
                compare_nibble("nibble_stream", model_reg.nibs[0], tx.nibble);
            end
            nib_in = sent_q.pop_front();
            model_reg.nibs = {nib_in, model_reg.nibs[SHIFT_NIBBLES-1:1]};
        end
        if (swap_ack) begin
            if (!swap_pending) begin
                report_failure("DUT acknowledged a swap that was never requested.");
            end
            addr                  = model_reg.fields.addr;
            old_word              = model_mem[addr];
            model_mem[addr]       = model_reg.fields.data;
            model_reg.fields.data = old_word;
            expect_fields         = model_reg.fields;
            collecting            = 1'b1;
            collect_cnt           = 0;
            swap_pending          = 1'b0;
            swaps_done++;
            nibbles_left = SHIFT_NIBBLES + int'(next_random() % 8);
        end
    endtask

    // Called at the rising edge; inputs change through non-blocking assignments.
    task automatic drive_inputs();
        logic [31:0] r;
        bit          send_ok;
        r       = next_random();
        send_ok = swap_pending ? (pend_sends < MAX_PEND_SENDS) : (nibbles_left > 0);
        if (host_rx_credits > 0 && send_ok && r[0]) begin
            rx.valid  <= 1'b1;
            rx.nibble <= r[7:4];
            sent_q.push_back(r[7:4]);
            host_rx_credits--;
            sent_total++;
            if (swap_pending) begin
                pend_sends++;
            end else begin
                nibbles_left--;
            end
        end else begin
            rx <= '0;
        end
        // Credits held back at random build pressure on the transmit side.
        if (tx_owed > 0 && r[8]) begin
            tx_credit <= 1'b1;
            tx_owed--;
        end else begin
            tx_credit <= 1'b0;
        end
        if (!swap_pending && swaps_done < NUM_SWAPS && nibbles_left == 0 && !collecting
                && sent_q.size() == 0 && r[16]) begin
            swap_req     <= 1'b1;
            swap_pending = 1'b1;
            pend_sends   = 0;
        end else if (!swap_pending) begin
            swap_req <= 1'b0;
        end
    endtask

    initial begin
        clk             = 1'b0;
        nRst            = 1'b0;
        rx              = '0;
        tx_credit       = 1'b0;
        swap_req        = 1'b0;
        rng_state       = 32'h14cf;
        model_reg       = '0;
        collected       = '0;
        expect_fields   = '0;
        host_rx_credits = RX_DEPTH;
        tx_owed         = 0;
        pend_sends      = 0;
        collect_cnt     = 0;
        sent_total      = 0;
        credits_back    = 0;
        swaps_done      = 0;
        swap_pending    = 1'b0;
        collecting      = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        nibbles_left = SHIFT_NIBBLES + int'(next_random() % 8);

        repeat (4) @(posedge clk);
        nRst <= 1'b1;

        // Nothing may come out before the host acts.
        repeat (8) begin
            @(negedge clk);
            if (tx.valid || rx_credit || swap_ack) begin
                report_failure("DUT produced output before the host sent anything.");
            end
        end

        while (!(swaps_done == NUM_SWAPS && nibbles_left == 0 && !collecting
                 && sent_q.size() == 0)) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            observe_outputs();
        end

        repeat (4) @(posedge clk);
        if (swap_top_i.nibble_shift_swap_i.swap_assert_i.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_failure("An assertion on the memory handshake failed.");
        end
    end

endmodule

`default_nettype wire

// File: src.f
source/swap_types_pkg.sv
source/mem_bus_pkg.sv
source/nibble_link.sv
source/nibble_shift_swap.sv
source/swap_mem.sv
source/swap_top.sv
verification/swap_assert.sv
verification/swap_tb.sv

// File: Makefile
# Verilator build and run for the nibble swap unit.

VERILATOR ?= verilator
TOP       ?= swap_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
